// ==== rtl/rvfi_trace_pkg.sv ====
package rvfi_trace_pkg;

  // Width of the cycle stamp kept in each record
  localparam int unsigned CYCLE_W = 20;

  // Trace memory depth unless the top level is told otherwise
  localparam int unsigned DEFAULT_DEPTH = 64;

  // RV32 major opcodes, bits [6:0] of the expanded instruction
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'h03,
    OPC_LOAD_FP  = 7'h07,
    OPC_MISC_MEM = 7'h0f,
    OPC_OP_IMM   = 7'h13,
    OPC_AUIPC    = 7'h17,
    OPC_STORE    = 7'h23,
    OPC_STORE_FP = 7'h27,
    OPC_AMO      = 7'h2f,
    OPC_OP       = 7'h33,
    OPC_LUI      = 7'h37,
    OPC_MADD     = 7'h43,
    OPC_MSUB     = 7'h47,
    OPC_NMSUB    = 7'h4b,
    OPC_NMADD    = 7'h4f,
    OPC_OP_FP    = 7'h53,
    OPC_BRANCH   = 7'h63,
    OPC_JALR     = 7'h67,
    OPC_JAL      = 7'h6f,
    OPC_SYSTEM   = 7'h73
  } opcode_e;

  typedef enum logic [2:0] {
    IMM_NONE  = 3'd0,
    IMM_I     = 3'd1,
    IMM_S     = 3'd2,
    IMM_B     = 3'd3,
    IMM_U     = 3'd4,
    IMM_J     = 3'd5,
    IMM_SHAMT = 3'd6
  } imm_fmt_e;

  // One retired instruction; register numbers carry the FP flag in bit 5
  typedef struct packed {
    logic [31:0]        pc;
    logic [31:0]        insn;
    logic               compressed;
    logic               hart;
    logic [5:0]         rd;
    logic [5:0]         rs1;
    logic [5:0]         rs2;
    logic [31:0]        rd_wdata;
    logic [31:0]        rs1_value;
    logic [31:0]        rs2_value;
    logic [31:0]        imm;
    imm_fmt_e           imm_fmt;
    logic [CYCLE_W-1:0] cycle;
  } trace_rec_t;

endpackage

// ==== rtl/rvc_expander.sv ====
`timescale 1ns/1ps

module rvc_expander import rvfi_trace_pkg::*; #(
  parameter int FPU = 0
) (
  input  logic [31:0] instr_i,
  output logic [31:0] instr_o,
  output logic        is_compressed_o
);

  logic [15:0] ci;

  assign ci = instr_i[15:0];
  assign is_compressed_o = (instr_i[1:0] != 2'b11);

  always_comb begin
    // Anything not recognised below leaves the expander unchanged
    instr_o = instr_i;
    unique case (ci[1:0])
      // Quadrant 0
      2'b00: begin
        unique case (ci[15:13])
          3'b000: begin
            // C.ADDI4SPN with a zero immediate is illegal
            if (ci[12:5] != 8'd0) begin
              instr_o = {2'b00, ci[10:7], ci[12:11], ci[5], ci[6], 2'b00, 5'd2,
                         3'b000, 2'b01, ci[4:2], OPC_OP_IMM};
            end
          end
          3'b010: begin
            instr_o = {5'd0, ci[5], ci[12:10], ci[6], 2'b00, 2'b01, ci[9:7],
                       3'b010, 2'b01, ci[4:2], OPC_LOAD};
          end
          3'b011: begin
            // C.FLW
            if (FPU != 0) begin
              instr_o = {5'd0, ci[5], ci[12:10], ci[6], 2'b00, 2'b01, ci[9:7],
                         3'b010, 2'b01, ci[4:2], OPC_LOAD_FP};
            end
          end
          3'b110: begin
            instr_o = {5'd0, ci[5], ci[12], 2'b01, ci[4:2], 2'b01, ci[9:7],
                       3'b010, ci[11:10], ci[6], 2'b00, OPC_STORE};
          end
          3'b111: begin
            // C.FSW
            if (FPU != 0) begin
              instr_o = {5'd0, ci[5], ci[12], 2'b01, ci[4:2], 2'b01, ci[9:7],
                         3'b010, ci[11:10], ci[6], 2'b00, OPC_STORE_FP};
            end
          end
          default: ;
        endcase
      end
      // Quadrant 1
      2'b01: begin
        unique case (ci[15:13])
          3'b000: begin
            instr_o = {{6{ci[12]}}, ci[12], ci[6:2], ci[11:7], 3'b000, ci[11:7], OPC_OP_IMM};
          end
          3'b001, 3'b101: begin
            // C.JAL links to x1 and C.J to x0
            instr_o = {ci[12], ci[8], ci[10:9], ci[6], ci[7], ci[2], ci[11], ci[5:3],
                       {9{ci[12]}}, 4'b0000, ~ci[15], OPC_JAL};
          end
          3'b010: begin
            instr_o = {{6{ci[12]}}, ci[12], ci[6:2], 5'd0, 3'b000, ci[11:7], OPC_OP_IMM};
          end
          3'b011: begin
            if ({ci[12], ci[6:2]} != 6'd0) begin
              if (ci[11:7] == 5'd2) begin
                // C.ADDI16SP
                instr_o = {{3{ci[12]}}, ci[4:3], ci[5], ci[2], ci[6], 4'b0000, 5'd2,
                           3'b000, 5'd2, OPC_OP_IMM};
              end else begin
                instr_o = {{15{ci[12]}}, ci[6:2], ci[11:7], OPC_LUI};
              end
            end
          end
          3'b100: begin
            unique case (ci[11:10])
              2'b00: instr_o = {7'b0000000, ci[6:2], 2'b01, ci[9:7], 3'b101,
                                2'b01, ci[9:7], OPC_OP_IMM};
              2'b01: instr_o = {7'b0100000, ci[6:2], 2'b01, ci[9:7], 3'b101,
                                2'b01, ci[9:7], OPC_OP_IMM};
              2'b10: instr_o = {{6{ci[12]}}, ci[12], ci[6:2], 2'b01, ci[9:7], 3'b111,
                                2'b01, ci[9:7], OPC_OP_IMM};
              default: begin
                // Register-register ALU group where ci[12] set is reserved in RV32
                if (!ci[12]) begin
                  unique case (ci[6:5])
                    2'b00: instr_o = {7'b0100000, 2'b01, ci[4:2], 2'b01, ci[9:7], 3'b000,
                                      2'b01, ci[9:7], OPC_OP};
                    2'b01: instr_o = {7'b0000000, 2'b01, ci[4:2], 2'b01, ci[9:7], 3'b100,
                                      2'b01, ci[9:7], OPC_OP};
                    2'b10: instr_o = {7'b0000000, 2'b01, ci[4:2], 2'b01, ci[9:7], 3'b110,
                                      2'b01, ci[9:7], OPC_OP};
                    default: instr_o = {7'b0000000, 2'b01, ci[4:2], 2'b01, ci[9:7], 3'b111,
                                        2'b01, ci[9:7], OPC_OP};
                  endcase
                end
              end
            endcase
          end
          default: begin
            // C.BEQZ and C.BNEZ take the low funct3 bit from ci[13]
            instr_o = {{4{ci[12]}}, ci[6:5], ci[2], 5'd0, 2'b01, ci[9:7], 2'b00, ci[13],
                       ci[11:10], ci[4:3], ci[12], OPC_BRANCH};
          end
        endcase
      end
      // Quadrant 2
      2'b10: begin
        unique case (ci[15:13])
          3'b000: instr_o = {7'b0000000, ci[6:2], ci[11:7], 3'b001, ci[11:7], OPC_OP_IMM};
          3'b010: instr_o = {4'b0000, ci[3:2], ci[12], ci[6:4], 2'b00, 5'd2, 3'b010,
                             ci[11:7], OPC_LOAD};
          3'b011: begin
            if (FPU != 0) begin
              instr_o = {4'b0000, ci[3:2], ci[12], ci[6:4], 2'b00, 5'd2, 3'b010,
                         ci[11:7], OPC_LOAD_FP};
            end
          end
          3'b100: begin
            if (ci[6:2] != 5'd0) begin
              // C.MV adds to x0 and C.ADD to rd
              instr_o = {7'b0000000, ci[6:2], ci[12] ? ci[11:7] : 5'd0, 3'b000,
                         ci[11:7], OPC_OP};
            end else if (ci[11:7] != 5'd0) begin
              instr_o = {12'd0, ci[11:7], 3'b000, 4'b0000, ci[12], OPC_JALR};
            end else if (ci[12]) begin
              instr_o = {12'd1, 13'd0, OPC_SYSTEM};
            end
          end
          3'b110: instr_o = {4'b0000, ci[8:7], ci[12], ci[6:2], 5'd2, 3'b010,
                             ci[11:9], 2'b00, OPC_STORE};
          3'b111: begin
            if (FPU != 0) begin
              instr_o = {4'b0000, ci[8:7], ci[12], ci[6:2], 5'd2, 3'b010,
                         ci[11:9], 2'b00, OPC_STORE_FP};
            end
          end
          default: ;
        endcase
      end
      default: ;
    endcase
  end

endmodule

// ==== rtl/rvfi_trace_capture.sv ====
`timescale 1ns/1ps

module rvfi_trace_capture import rvfi_trace_pkg::*; #(
  parameter int FPU     = 0,
  parameter int HART_ID = 0
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        rvfi_valid_i,
  input  logic [31:0] rvfi_insn_i,
  input  logic [31:0] rvfi_pc_i,
  input  logic [4:0]  rvfi_rd_addr_i,
  input  logic [31:0] rvfi_rd_wdata_i,
  input  logic        rvfi_frd_wvalid_i,
  input  logic [4:0]  rvfi_frd_addr_i,
  input  logic [4:0]  rvfi_rs1_addr_i,
  input  logic [4:0]  rvfi_rs2_addr_i,
  input  logic [31:0] rvfi_rs1_rdata_i,
  input  logic [31:0] rvfi_rs2_rdata_i,
  input  logic        rvfi_frs1_rvalid_i,
  input  logic        rvfi_frs2_rvalid_i,
  input  logic [4:0]  rvfi_frs1_addr_i,
  input  logic [4:0]  rvfi_frs2_addr_i,
  input  logic [31:0] rvfi_frs1_rdata_i,
  input  logic [31:0] rvfi_frs2_rdata_i,
  input  logic        gnt_i,
  output logic        req_o,
  output trace_rec_t  rec_o,
  output logic [7:0]  drops_o
);

  logic [31:0]        insn;
  logic               is_compressed;
  logic               fp_rd;
  logic               fp_rs1;
  logic               fp_rs2;
  opcode_e            opcode;
  imm_fmt_e           imm_fmt;
  logic [31:0]        imm;
  trace_rec_t         new_rec;
  logic [CYCLE_W-1:0] cycle_q;
  logic               pend_q;
  trace_rec_t         pend_rec_q;
  logic [7:0]         drops_q;
  logic               load_new;

  rvc_expander #(
    .FPU(FPU)
  ) rvc_expander_i (
    .instr_i        (rvfi_insn_i),
    .instr_o        (insn),
    .is_compressed_o(is_compressed)
  );

  // FP operands are only taken when the FPU is present
  assign fp_rd  = (FPU != 0) && rvfi_frd_wvalid_i;
  assign fp_rs1 = (FPU != 0) && rvfi_frs1_rvalid_i;
  assign fp_rs2 = (FPU != 0) && rvfi_frs2_rvalid_i;

  assign opcode = opcode_e'(insn[6:0]);

  always_comb begin
    unique case (opcode)
      OPC_LOAD, OPC_LOAD_FP, OPC_JALR, OPC_SYSTEM: imm_fmt = IMM_I;
      OPC_OP_IMM: imm_fmt = (insn[13:12] == 2'b01) ? IMM_SHAMT : IMM_I;
      OPC_STORE, OPC_STORE_FP: imm_fmt = IMM_S;
      OPC_BRANCH: imm_fmt = IMM_B;
      OPC_LUI, OPC_AUIPC: imm_fmt = IMM_U;
      OPC_JAL: imm_fmt = IMM_J;
      default: imm_fmt = IMM_NONE;
    endcase
  end

  always_comb begin
    unique case (imm_fmt)
      IMM_I: imm = {{20{insn[31]}}, insn[31:20]};
      IMM_S: imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
      IMM_B: imm = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      IMM_U: imm = {insn[31:12], 12'd0};
      IMM_J: imm = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
      IMM_SHAMT: imm = {27'd0, insn[24:20]};
      default: imm = 32'd0;
    endcase
  end

  always_comb begin
    new_rec            = '0;
    new_rec.pc         = rvfi_pc_i;
    new_rec.insn       = insn;
    new_rec.compressed = is_compressed;
    new_rec.hart       = 1'(HART_ID);
    new_rec.rd         = fp_rd ? {1'b1, rvfi_frd_addr_i} : {1'b0, rvfi_rd_addr_i};
    new_rec.rd_wdata   = rvfi_rd_wdata_i;
    new_rec.rs1        = fp_rs1 ? {1'b1, rvfi_frs1_addr_i} : {1'b0, rvfi_rs1_addr_i};
    new_rec.rs1_value  = fp_rs1 ? rvfi_frs1_rdata_i : rvfi_rs1_rdata_i;
    new_rec.rs2        = fp_rs2 ? {1'b1, rvfi_frs2_addr_i} : {1'b0, rvfi_rs2_addr_i};
    new_rec.rs2_value  = fp_rs2 ? rvfi_frs2_rdata_i : rvfi_rs2_rdata_i;
    new_rec.imm        = imm;
    new_rec.imm_fmt    = imm_fmt;
    // Stamp with the count from before this edge
    new_rec.cycle      = cycle_q;
  end

  // A free slot, or one being granted this cycle, can take the new record
  assign load_new = rvfi_valid_i && (!pend_q || gnt_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q <= '0;
      pend_q  <= 1'b0;
      drops_q <= 8'd0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
      if (load_new) begin
        pend_q <= 1'b1;
      end else if (gnt_i) begin
        pend_q <= 1'b0;
      end
      if (rvfi_valid_i && !load_new && drops_q != 8'hff) begin
        drops_q <= drops_q + 8'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_new) begin
      pend_rec_q <= new_rec;
    end
  end

  assign req_o   = pend_q;
  assign rec_o   = pend_rec_q;
  assign drops_o = drops_q;

endmodule

// ==== rtl/trace_arbiter.sv ====
`timescale 1ns/1ps

module trace_arbiter import rvfi_trace_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req0_i,
  input  logic       req1_i,
  input  trace_rec_t rec0_i,
  input  trace_rec_t rec1_i,
  output logic       gnt0_o,
  output logic       gnt1_o,
  output logic       wr_en_o,
  output trace_rec_t wr_rec_o
);

  // Set when hart 1 won the last grant
  logic last1_q;

  // On a tie the hart not granted last wins
  assign gnt0_o = req0_i && (!req1_i || last1_q);
  assign gnt1_o = req1_i && (!req0_i || !last1_q);

  assign wr_en_o  = gnt0_o || gnt1_o;
  assign wr_rec_o = gnt1_o ? rec1_i : rec0_i;

  // Starts as if hart 1 had been granted, so hart 0 goes first
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last1_q <= 1'b1;
    end else if (wr_en_o) begin
      last1_q <= gnt1_o;
    end
  end

endmodule

// ==== rtl/trace_store.sv ====
`timescale 1ns/1ps

module trace_store import rvfi_trace_pkg::*; #(
  parameter int DEPTH = DEFAULT_DEPTH
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       wr_en_i,
  input  trace_rec_t                 wr_rec_i,
  input  logic [$clog2(DEPTH)-1:0]   rd_addr_i,
  output trace_rec_t                 rd_data_o,
  output logic [$clog2(DEPTH+1)-1:0] count_o,
  output logic                       full_o
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH+1);

  trace_rec_t    mem [DEPTH];
  trace_rec_t    rd_data_q;
  logic [CW-1:0] count_q;
  logic          full_q;
  logic          store;

  // Grants after the memory fills are accepted and discarded
  assign store = wr_en_i && !full_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
      full_q  <= 1'b0;
    end else if (store) begin
      count_q <= count_q + 1'b1;
      if (count_q == CW'(DEPTH - 1)) begin
        full_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (store) begin
      mem[count_q[AW-1:0]] <= wr_rec_i;
    end
    rd_data_q <= mem[rd_addr_i];
  end

  assign rd_data_o = rd_data_q;
  assign count_o   = count_q;
  assign full_o    = full_q;

endmodule

// ==== rtl/rvfi_trace_top.sv ====
`timescale 1ns/1ps

module rvfi_trace_top import rvfi_trace_pkg::*; #(
  parameter int FPU   = 0,
  parameter int DEPTH = DEFAULT_DEPTH
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       rvfi_valid_0_i,
  input  logic [31:0]                rvfi_insn_0_i,
  input  logic [31:0]                rvfi_pc_0_i,
  input  logic [4:0]                 rvfi_rd_addr_0_i,
  input  logic [31:0]                rvfi_rd_wdata_0_i,
  input  logic                       rvfi_frd_wvalid_0_i,
  input  logic [4:0]                 rvfi_frd_addr_0_i,
  input  logic [4:0]                 rvfi_rs1_addr_0_i,
  input  logic [4:0]                 rvfi_rs2_addr_0_i,
  input  logic [31:0]                rvfi_rs1_rdata_0_i,
  input  logic [31:0]                rvfi_rs2_rdata_0_i,
  input  logic                       rvfi_frs1_rvalid_0_i,
  input  logic                       rvfi_frs2_rvalid_0_i,
  input  logic [4:0]                 rvfi_frs1_addr_0_i,
  input  logic [4:0]                 rvfi_frs2_addr_0_i,
  input  logic [31:0]                rvfi_frs1_rdata_0_i,
  input  logic [31:0]                rvfi_frs2_rdata_0_i,
  input  logic                       rvfi_valid_1_i,
  input  logic [31:0]                rvfi_insn_1_i,
  input  logic [31:0]                rvfi_pc_1_i,
  input  logic [4:0]                 rvfi_rd_addr_1_i,
  input  logic [31:0]                rvfi_rd_wdata_1_i,
  input  logic                       rvfi_frd_wvalid_1_i,
  input  logic [4:0]                 rvfi_frd_addr_1_i,
  input  logic [4:0]                 rvfi_rs1_addr_1_i,
  input  logic [4:0]                 rvfi_rs2_addr_1_i,
  input  logic [31:0]                rvfi_rs1_rdata_1_i,
  input  logic [31:0]                rvfi_rs2_rdata_1_i,
  input  logic                       rvfi_frs1_rvalid_1_i,
  input  logic                       rvfi_frs2_rvalid_1_i,
  input  logic [4:0]                 rvfi_frs1_addr_1_i,
  input  logic [4:0]                 rvfi_frs2_addr_1_i,
  input  logic [31:0]                rvfi_frs1_rdata_1_i,
  input  logic [31:0]                rvfi_frs2_rdata_1_i,
  input  logic [$clog2(DEPTH)-1:0]   rd_addr_i,
  output trace_rec_t                 rd_data_o,
  output logic [$clog2(DEPTH+1)-1:0] count_o,
  output logic                       full_o,
  output logic [7:0]                 drops_0_o,
  output logic [7:0]                 drops_1_o
);

  logic       req0;
  logic       req1;
  logic       gnt0;
  logic       gnt1;
  trace_rec_t rec0;
  trace_rec_t rec1;
  logic       wr_en;
  trace_rec_t wr_rec;

  rvfi_trace_capture #(
    .FPU    (FPU),
    .HART_ID(0)
  ) rvfi_trace_capture_0_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .rvfi_valid_i      (rvfi_valid_0_i),
    .rvfi_insn_i       (rvfi_insn_0_i),
    .rvfi_pc_i         (rvfi_pc_0_i),
    .rvfi_rd_addr_i    (rvfi_rd_addr_0_i),
    .rvfi_rd_wdata_i   (rvfi_rd_wdata_0_i),
    .rvfi_frd_wvalid_i (rvfi_frd_wvalid_0_i),
    .rvfi_frd_addr_i   (rvfi_frd_addr_0_i),
    .rvfi_rs1_addr_i   (rvfi_rs1_addr_0_i),
    .rvfi_rs2_addr_i   (rvfi_rs2_addr_0_i),
    .rvfi_rs1_rdata_i  (rvfi_rs1_rdata_0_i),
    .rvfi_rs2_rdata_i  (rvfi_rs2_rdata_0_i),
    .rvfi_frs1_rvalid_i(rvfi_frs1_rvalid_0_i),
    .rvfi_frs2_rvalid_i(rvfi_frs2_rvalid_0_i),
    .rvfi_frs1_addr_i  (rvfi_frs1_addr_0_i),
    .rvfi_frs2_addr_i  (rvfi_frs2_addr_0_i),
    .rvfi_frs1_rdata_i (rvfi_frs1_rdata_0_i),
    .rvfi_frs2_rdata_i (rvfi_frs2_rdata_0_i),
    .gnt_i             (gnt0),
    .req_o             (req0),
    .rec_o             (rec0),
    .drops_o           (drops_0_o)
  );

  rvfi_trace_capture #(
    .FPU    (FPU),
    .HART_ID(1)
  ) rvfi_trace_capture_1_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .rvfi_valid_i      (rvfi_valid_1_i),
    .rvfi_insn_i       (rvfi_insn_1_i),
    .rvfi_pc_i         (rvfi_pc_1_i),
    .rvfi_rd_addr_i    (rvfi_rd_addr_1_i),
    .rvfi_rd_wdata_i   (rvfi_rd_wdata_1_i),
    .rvfi_frd_wvalid_i (rvfi_frd_wvalid_1_i),
    .rvfi_frd_addr_i   (rvfi_frd_addr_1_i),
    .rvfi_rs1_addr_i   (rvfi_rs1_addr_1_i),
    .rvfi_rs2_addr_i   (rvfi_rs2_addr_1_i),
    .rvfi_rs1_rdata_i  (rvfi_rs1_rdata_1_i),
    .rvfi_rs2_rdata_i  (rvfi_rs2_rdata_1_i),
    .rvfi_frs1_rvalid_i(rvfi_frs1_rvalid_1_i),
    .rvfi_frs2_rvalid_i(rvfi_frs2_rvalid_1_i),
    .rvfi_frs1_addr_i  (rvfi_frs1_addr_1_i),
    .rvfi_frs2_addr_i  (rvfi_frs2_addr_1_i),
    .rvfi_frs1_rdata_i (rvfi_frs1_rdata_1_i),
    .rvfi_frs2_rdata_i (rvfi_frs2_rdata_1_i),
    .gnt_i             (gnt1),
    .req_o             (req1),
    .rec_o             (rec1),
    .drops_o           (drops_1_o)
  );

  trace_arbiter trace_arbiter_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req0_i  (req0),
    .req1_i  (req1),
    .rec0_i  (rec0),
    .rec1_i  (rec1),
    .gnt0_o  (gnt0),
    .gnt1_o  (gnt1),
    .wr_en_o (wr_en),
    .wr_rec_o(wr_rec)
  );

  trace_store #(
    .DEPTH(DEPTH)
  ) trace_store_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wr_en_i  (wr_en),
    .wr_rec_i (wr_rec),
    .rd_addr_i(rd_addr_i),
    .rd_data_o(rd_data_o),
    .count_o  (count_o),
    .full_o   (full_o)
  );

endmodule

// ==== verif/tb_rvfi_trace_model.svh ====
`ifndef TB_RVFI_TRACE_MODEL_SVH
`define TB_RVFI_TRACE_MODEL_SVH

// Major opcodes used for uncompressed stimulus
function automatic logic [6:0] pick_opcode(input logic [3:0] idx);
  case (idx)
    4'd0: return OPC_LOAD;
    4'd1: return OPC_LOAD_FP;
    4'd2: return OPC_OP_IMM;
    4'd3: return OPC_AUIPC;
    4'd4: return OPC_STORE;
    4'd5: return OPC_STORE_FP;
    4'd6: return OPC_OP;
    4'd7: return OPC_LUI;
    4'd8: return OPC_BRANCH;
    4'd9: return OPC_JALR;
    4'd10: return OPC_JAL;
    4'd11: return OPC_SYSTEM;
    default: return OPC_OP_FP;
  endcase
endfunction

// Immediate format and value as the base ISA defines them
function automatic void decode_imm(input logic [31:0] x, output imm_fmt_e fmt,
                                   output logic [31:0] imm);
  logic [2:0] f3;
  f3 = x[14:12];
  case (x[6:0])
    OPC_LOAD, OPC_LOAD_FP, OPC_JALR, OPC_SYSTEM: fmt = IMM_I;
    OPC_OP_IMM: fmt = (f3 == 3'd1 || f3 == 3'd5) ? IMM_SHAMT : IMM_I;
    OPC_STORE, OPC_STORE_FP: fmt = IMM_S;
    OPC_BRANCH: fmt = IMM_B;
    OPC_LUI, OPC_AUIPC: fmt = IMM_U;
    OPC_JAL: fmt = IMM_J;
    default: fmt = IMM_NONE;
  endcase
  case (fmt)
    IMM_I: imm = $signed(x[31:20]);
    IMM_S: imm = $signed({x[31:25], x[11:7]});
    IMM_B: imm = $signed({x[31], x[7], x[30:25], x[11:8], 1'b0});
    IMM_U: imm = {x[31:12], 12'd0};
    IMM_J: imm = $signed({x[31], x[19:12], x[20], x[30:21], 1'b0});
    IMM_SHAMT: imm = {27'd0, x[24:20]};
    default: imm = 32'd0;
  endcase
endfunction

// Encodes a random compressed instruction and its 32-bit equivalent
function automatic void make_compressed(input logic [31:0] r, output logic [15:0] c,
                                        output logic [31:0] x);
  logic [6:0] off;
  logic [2:0] a;
  logic [2:0] b;
  logic [4:0] rd;
  logic [5:0] im;
  off = {r[8:4], 2'b00};
  a   = r[11:9];
  b   = r[14:12];
  rd  = r[19:15];
  im  = r[25:20];
  case (r[2:0])
    3'd0, 3'd1, 3'd6: begin
      // C.LW for selector 0 and C.FLW for the other two
      c = {(r[2:0] == 3'd0) ? 3'b010 : 3'b011, off[5:3], a, off[2], off[6], b, 2'b00};
      x = {5'd0, off, 2'b01, a, 3'b010, 2'b01, b,
           (r[2:0] == 3'd0) ? 7'(OPC_LOAD) : 7'(OPC_LOAD_FP)};
    end
    3'd2, 3'd3, 3'd7: begin
      c = {(r[2:0] == 3'd2) ? 3'b110 : 3'b111, off[5:3], a, off[2], off[6], b, 2'b00};
      x = {5'd0, off[6:5], 2'b01, b, 2'b01, a, 3'b010, off[4:0],
           (r[2:0] == 3'd2) ? 7'(OPC_STORE) : 7'(OPC_STORE_FP)};
    end
    3'd4: begin
      c = {3'b000, im[5], rd, im[4:0], 2'b01};
      x = {{6{im[5]}}, im, rd, 3'b000, rd, 7'(OPC_OP_IMM)};
    end
    default: begin
      // C.LI adds to x0
      c = {3'b010, im[5], rd, im[4:0], 2'b01};
      x = {{6{im[5]}}, im, 5'd0, 3'b000, rd, 7'(OPC_OP_IMM)};
    end
  endcase
endfunction

// Expected record from what is currently driven on hart h
function automatic trace_rec_t expected_rec(input int h, input logic [19:0] stamp);
  trace_rec_t r;
  imm_fmt_e   fmt;
  logic [31:0] imm;
  decode_imm(exp_insn_d[h], fmt, imm);
  r            = '0;
  r.pc         = pc[h];
  r.insn       = exp_insn_d[h];
  r.compressed = comp_d[h];
  r.hart       = 1'(h);
  r.rd         = frd_wv[h] ? {1'b1, frd_addr[h]} : {1'b0, rd_addr[h]};
  r.rd_wdata   = rd_wdata[h];
  r.rs1        = frs1_rv[h] ? {1'b1, frs1_addr[h]} : {1'b0, rs1_addr[h]};
  r.rs1_value  = frs1_rv[h] ? frs1_rdata[h] : rs1_rdata[h];
  r.rs2        = frs2_rv[h] ? {1'b1, frs2_addr[h]} : {1'b0, rs2_addr[h]};
  r.rs2_value  = frs2_rv[h] ? frs2_rdata[h] : rs2_rdata[h];
  r.imm        = imm;
  r.imm_fmt    = fmt;
  r.cycle      = stamp;
  return r;
endfunction

task automatic check_rec(input trace_rec_t got, input trace_rec_t exp, input int idx);
  if (got !== exp) begin
    $display("  got %h", got);
    $display("  exp %h", exp);
    abort_run($sformatf("record %0d differs", idx));
  end
endtask

task automatic check_count(input logic [6:0] got, input logic [6:0] exp);
  if (got !== exp) begin
    abort_run($sformatf("count_o is %0d, expected %0d", got, exp));
  end
endtask

task automatic check_drops(input logic [7:0] got, input logic [7:0] exp, input int h);
  if (got !== exp) begin
    abort_run($sformatf("drops of hart %0d are %0d, expected %0d", h, got, exp));
  end
endtask

task automatic check_flag(input logic got, input logic exp, input string name);
  if (got !== exp) begin
    abort_run($sformatf("%s is %b, expected %b", name, got, exp));
  end
endtask

`endif

// ==== verif/tb_rvfi_trace.sv ====
`timescale 1ns/1ps

module tb_rvfi_trace import rvfi_trace_pkg::*; ();

  localparam int DEPTH = DEFAULT_DEPTH;
  localparam int P_SPARSE = 24;
  localparam int P_COMP = 16;
  localparam int P_DENSE = 80;
  localparam int P_DENSE_A = P_DENSE / 4;
  localparam int P_DRAIN = 4;
  localparam int P_IDLE = 6;
  localparam int STIM_CYCLES = 5 + P_SPARSE + P_COMP + P_DENSE + P_DRAIN + P_IDLE;
  localparam int LIMIT = STIM_CYCLES + DEPTH + 100;

  logic clk_i;
  logic rst_ni;
  logic        valid [2];
  logic [31:0] insn [2];
  logic [31:0] pc [2];
  logic [4:0]  rd_addr [2];
  logic [31:0] rd_wdata [2];
  logic        frd_wv [2];
  logic [4:0]  frd_addr [2];
  logic [4:0]  rs1_addr [2];
  logic [4:0]  rs2_addr [2];
  logic [31:0] rs1_rdata [2];
  logic [31:0] rs2_rdata [2];
  logic        frs1_rv [2];
  logic        frs2_rv [2];
  logic [4:0]  frs1_addr [2];
  logic [4:0]  frs2_addr [2];
  logic [31:0] frs1_rdata [2];
  logic [31:0] frs2_rdata [2];
  logic [5:0]  rd_addr_i;
  trace_rec_t  rd_data;
  logic [6:0]  count;
  logic        full;
  logic [7:0]  drops [2];

  // What the driven instruction should look like after expansion
  logic [31:0] exp_insn_d [2];
  logic        comp_d [2];

  // Reference model state
  logic [31:0] seed = 32'h2455574f;
  logic        pend_v [2];
  trace_rec_t  pend_r [2];
  logic        last1;
  int          drops_m [2];
  int          retired [2];
  int          granted;
  logic [19:0] cyc;
  trace_rec_t  exp_q [$];
  int          tick;

  task automatic abort_run(input string msg);
    $display("Fail %0t: %s", $time, msg);
    $display("STATUS: FAIL");
    $fatal(1, "check failed");
  endtask

  `include "tb_rvfi_trace_model.svh"

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  rvfi_trace_top #(
    .FPU  (1),
    .DEPTH(DEPTH)
  ) rvfi_trace_top_i (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .rvfi_valid_0_i(valid[0]), .rvfi_insn_0_i(insn[0]), .rvfi_pc_0_i(pc[0]),
    .rvfi_rd_addr_0_i(rd_addr[0]), .rvfi_rd_wdata_0_i(rd_wdata[0]),
    .rvfi_frd_wvalid_0_i(frd_wv[0]), .rvfi_frd_addr_0_i(frd_addr[0]),
    .rvfi_rs1_addr_0_i(rs1_addr[0]), .rvfi_rs2_addr_0_i(rs2_addr[0]),
    .rvfi_rs1_rdata_0_i(rs1_rdata[0]), .rvfi_rs2_rdata_0_i(rs2_rdata[0]),
    .rvfi_frs1_rvalid_0_i(frs1_rv[0]), .rvfi_frs2_rvalid_0_i(frs2_rv[0]),
    .rvfi_frs1_addr_0_i(frs1_addr[0]), .rvfi_frs2_addr_0_i(frs2_addr[0]),
    .rvfi_frs1_rdata_0_i(frs1_rdata[0]), .rvfi_frs2_rdata_0_i(frs2_rdata[0]),
    .rvfi_valid_1_i(valid[1]), .rvfi_insn_1_i(insn[1]), .rvfi_pc_1_i(pc[1]),
    .rvfi_rd_addr_1_i(rd_addr[1]), .rvfi_rd_wdata_1_i(rd_wdata[1]),
    .rvfi_frd_wvalid_1_i(frd_wv[1]), .rvfi_frd_addr_1_i(frd_addr[1]),
    .rvfi_rs1_addr_1_i(rs1_addr[1]), .rvfi_rs2_addr_1_i(rs2_addr[1]),
    .rvfi_rs1_rdata_1_i(rs1_rdata[1]), .rvfi_rs2_rdata_1_i(rs2_rdata[1]),
    .rvfi_frs1_rvalid_1_i(frs1_rv[1]), .rvfi_frs2_rvalid_1_i(frs2_rv[1]),
    .rvfi_frs1_addr_1_i(frs1_addr[1]), .rvfi_frs2_addr_1_i(frs2_addr[1]),
    .rvfi_frs1_rdata_1_i(frs1_rdata[1]), .rvfi_frs2_rdata_1_i(frs2_rdata[1]),
    .rd_addr_i(rd_addr_i), .rd_data_o(rd_data), .count_o(count), .full_o(full),
    .drops_0_o(drops[0]), .drops_1_o(drops[1])
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    tick <= tick + 1;
    if (tick > LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", LIMIT);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end
  end

  // Pending slot and round-robin model run on the inputs sampled at this edge
  task automatic model_edge();
    logic g [2];
    if (!rst_ni) begin
      return;
    end
    g[0] = pend_v[0] && (!pend_v[1] || last1);
    g[1] = pend_v[1] && (!pend_v[0] || !last1);
    if (g[0] || g[1]) begin
      granted++;
      if (exp_q.size() < DEPTH) begin
        exp_q.push_back(g[1] ? pend_r[1] : pend_r[0]);
      end
      last1 = g[1];
    end
    for (int h = 0; h < 2; h++) begin
      if (valid[h]) begin
        retired[h]++;
        if (!pend_v[h] || g[h]) begin
          pend_v[h] = 1'b1;
          pend_r[h] = expected_rec(h, cyc);
        end else begin
          drops_m[h]++;
        end
      end else if (g[h]) begin
        pend_v[h] = 1'b0;
      end
    end
    cyc++;
  endtask

  // Mode 0 idle, 1 sparse uncompressed, 2 sparse compressed, 3 every cycle mixed
  task automatic drive_hart(input int h, input int mode);
    logic [31:0] r;
    logic [31:0] u;
    logic [15:0] c;
    logic [31:0] x;
    logic        go;
    r  = next_rand();
    go = (mode == 3) || (mode != 0 && r[1:0] == 2'b00);
    valid[h] <= go;
    if (mode == 2 || (mode == 3 && r[5])) begin
      make_compressed(next_rand(), c, x);
      insn[h]       <= {16'd0, c};
      exp_insn_d[h] = x;
      comp_d[h]     = 1'b1;
    end else begin
      u = next_rand();
      x = {u[31:7], pick_opcode(4'(u[3:0] % 13))};
      insn[h]       <= x;
      exp_insn_d[h] = x;
      comp_d[h]     = 1'b0;
    end
    u = next_rand();
    rd_addr[h]   <= u[4:0];
    frd_addr[h]  <= u[9:5];
    rs1_addr[h]  <= u[14:10];
    rs2_addr[h]  <= u[19:15];
    frs1_addr[h] <= u[24:20];
    frs2_addr[h] <= u[29:25];
    frd_wv[h]    <= r[8];
    frs1_rv[h]   <= r[9];
    frs2_rv[h]   <= r[10];
    pc[h]         <= {next_rand() & 32'hffff_fffe};
    rd_wdata[h]   <= next_rand();
    rs1_rdata[h]  <= next_rand();
    rs2_rdata[h]  <= next_rand();
    frs1_rdata[h] <= next_rand();
    frs2_rdata[h] <= next_rand();
  endtask

  task automatic run_cycles(input int n, input int mode0, input int mode1);
    repeat (n) begin
      @(posedge clk_i);
      model_edge();
      drive_hart(0, mode0);
      drive_hart(1, mode1);
    end
  endtask

  initial begin
    clk_i = 1'b0;
    rst_ni = 1'b0;
    rd_addr_i = '0;
    tick = 0;
    last1 = 1'b1;
    granted = 0;
    cyc = '0;
    for (int h = 0; h < 2; h++) begin
      valid[h] = 1'b0;
      insn[h] = '0;
      pc[h] = '0;
      rd_addr[h] = '0;
      rd_wdata[h] = '0;
      frd_wv[h] = 1'b0;
      frd_addr[h] = '0;
      rs1_addr[h] = '0;
      rs2_addr[h] = '0;
      rs1_rdata[h] = '0;
      rs2_rdata[h] = '0;
      frs1_rv[h] = 1'b0;
      frs2_rv[h] = 1'b0;
      frs1_addr[h] = '0;
      frs2_addr[h] = '0;
      frs1_rdata[h] = '0;
      frs2_rdata[h] = '0;
      exp_insn_d[h] = '0;
      comp_d[h] = 1'b0;
      pend_v[h] = 1'b0;
      drops_m[h] = 0;
      retired[h] = 0;
    end
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    check_flag(full, 1'b0, "full_o after reset");
    check_count(count, 7'd0);
    for (int h = 0; h < 2; h++) begin
      check_drops(drops[h], 8'd0, h);
    end

    // Single hart first, then both harts every cycle with a pause before the memory fills
    run_cycles(P_SPARSE, 1, 0);
    run_cycles(P_COMP, 2, 0);
    run_cycles(P_DENSE_A, 3, 3);
    run_cycles(P_DRAIN, 0, 0);

    // Until the memory fills every retire is either stored or dropped
    check_flag(full, 1'b0, "full_o before the memory fills");
    if (count + drops[0] + drops[1] != retired[0] + retired[1]) begin
      abort_run("stored plus dropped does not match retired");
    end

    run_cycles(P_DENSE - P_DENSE_A, 3, 3);
    run_cycles(P_IDLE, 0, 0);

    check_count(count, 7'(exp_q.size()));
    check_flag(full, granted >= DEPTH, "full_o");
    for (int h = 0; h < 2; h++) begin
      check_drops(drops[h], 8'(drops_m[h]), h);
    end

    // Address goes out at edge i and its data is checked two edges later
    for (int i = 0; i < exp_q.size() + 2; i++) begin
      @(posedge clk_i);
      if (i >= 2) begin
        check_rec(rd_data, exp_q[i-2], i - 2);
      end
      if (i < exp_q.size()) begin
        rd_addr_i <= 6'(i);
      end
    end
    check_flag(full, 1'b1, "full_o at end");

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+verif
rtl/rvfi_trace_pkg.sv
rtl/rvc_expander.sv
rtl/rvfi_trace_capture.sv
rtl/trace_arbiter.sv
rtl/trace_store.sv
rtl/rvfi_trace_top.sv
verif/tb_rvfi_trace.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rvfi_trace
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(wildcard rtl/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(BUILD_DIR)
